// ==== hw/vin_pkg.sv ====
`default_nettype none

package vin_pkg;

    // --------------------
    // video word geometry
    // --------------------

    // camera lanes per clock
    localparam int VIN_LANES  = 10;
    // bits per lane
    localparam int VIN_LANE_W = 8;
    // full word, lane 0 in the low byte
    localparam int VIN_WORD_W = VIN_LANES * VIN_LANE_W;
    // shared width of line, word and sum counters
    localparam int VIN_CNT_W  = 16;

    // --------------------
    // per-frame reports
    // --------------------

    // timing report of one tracked frame
    typedef struct packed {
        // lines seen in the frame
        logic [VIN_CNT_W-1:0] lines;
        // words in the last line only
        logic [VIN_CNT_W-1:0] words;
    } vin_timing_rpt_t;

    // checksum report of one tracked frame
    typedef struct packed {
        // byte sum, modulo 2^16
        logic [VIN_CNT_W-1:0] sum;
    } vin_sum_rpt_t;

endpackage

`default_nettype wire

// ==== hw/usr_pkg.sv ====
`default_nettype none

package usr_pkg;

    // user port data width, both directions
    localparam int USR_DATA_W = 16;

    // --------------------
    // command word
    // --------------------

    // opcode in txd[15:12]
    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        // txd[0] is the capture enable
        OP_ENABLE = 4'h1,
        // txd[3:0] picks the read register
        OP_SELECT = 4'h2,
        // frame count and overrun back to zero
        OP_CLEAR  = 4'h3
    } usr_op_e;

    // readable registers
    typedef enum logic [3:0] {
        SEL_LINES  = 4'h0,
        SEL_WORDS  = 4'h1,
        SEL_SUM    = 4'h2,
        SEL_FRAMES = 4'h3
    } usr_sel_e;

    // status byte, bit 0 first from the bottom
    typedef struct packed {
        logic [4:0] rsvd;
        logic       overrun;
        logic       report_ready;
        logic       enable;
    } usr_status_t;

endpackage

`default_nettype wire

// ==== hw/vin_timing_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module vin_timing_monitor (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_en,
    input  logic                     i_vin_vs,
    input  logic                     i_vin_hs,
    output logic                     o_done,
    output vin_pkg::vin_timing_rpt_t o_rpt
);

    import vin_pkg::*;

    logic                 vs_q;
    logic                 hs_q;
    logic                 track;
    logic                 vs_rise;
    logic                 vs_fall;
    logic                 act;
    logic                 act_q;
    logic [VIN_CNT_W-1:0] line_cnt;
    logic [VIN_CNT_W-1:0] word_cnt;
    logic [VIN_CNT_W-1:0] line_nxt;
    logic [VIN_CNT_W-1:0] word_nxt;

    // counters stick at all ones
    function automatic logic [VIN_CNT_W-1:0] sat_inc(input logic [VIN_CNT_W-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    // --------------------
    // strobe edges
    // --------------------
    assign vs_rise = i_vin_vs & ~vs_q;
    assign vs_fall = ~i_vin_vs & vs_q;
    // active word, now and one cycle back
    assign act   = i_vin_vs & i_vin_hs;
    assign act_q = vs_q & hs_q;

    // next counts, also used as the report at frame end
    always_comb begin
        line_nxt = line_cnt;
        word_nxt = word_cnt;
        // new frame
        if (vs_rise) begin
            line_nxt = '0;
            word_nxt = '0;
        end
        // first word of a line restarts the word count
        if (act & ~act_q)
            word_nxt = '0;
        if (act)
            word_nxt = sat_inc(word_nxt);
        // hs falls inside the frame, one more line
        if (act_q & ~act)
            line_nxt = sat_inc(line_nxt);
    end

    // --------------------
    // state and report
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vs_q     <= 1'b0;
            hs_q     <= 1'b0;
            track    <= 1'b0;
            line_cnt <= '0;
            word_cnt <= '0;
            o_done   <= 1'b0;
            o_rpt    <= '0;
        end else begin
            vs_q     <= i_vin_vs;
            hs_q     <= i_vin_hs;
            line_cnt <= line_nxt;
            word_cnt <= word_nxt;
            o_done   <= vs_fall & track;
            // enable sampled once per frame
            if (vs_rise)
                track <= i_en;
            else if (vs_fall)
                track <= 1'b0;
            // report held until the next tracked frame ends
            if (vs_fall & track) begin
                o_rpt.lines <= line_nxt;
                o_rpt.words <= word_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/vin_frame_checksum.sv ====
`timescale 1ns/100ps
`default_nettype none

module vin_frame_checksum (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_en,
    input  logic                           i_vin_vs,
    input  logic                           i_vin_hs,
    input  logic [vin_pkg::VIN_WORD_W-1:0] i_vin_d,
    output logic                           o_done,
    output vin_pkg::vin_sum_rpt_t          o_rpt
);

    import vin_pkg::*;

    logic                 vs_q;
    logic                 track;
    logic                 vs_rise;
    logic                 vs_fall;
    logic                 act;
    logic [VIN_CNT_W-1:0] byte_sum;
    logic [VIN_CNT_W-1:0] acc;

    // own vs edge detect
    assign vs_rise  = i_vin_vs & ~vs_q;
    assign vs_fall  = ~i_vin_vs & vs_q;
    assign act      = i_vin_vs & i_vin_hs;

    // sum of the ten lane bytes of this word
    always_comb begin
        byte_sum = '0;
        for (int i = 0; i < VIN_LANES; i++)
            byte_sum = byte_sum + VIN_CNT_W'(i_vin_d[i*VIN_LANE_W +: VIN_LANE_W]);
    end

    // --------------------
    // accumulator
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vs_q   <= 1'b0;
            track  <= 1'b0;
            acc    <= '0;
            o_done <= 1'b0;
            o_rpt  <= '0;
        end else begin
            vs_q   <= i_vin_vs;
            o_done <= vs_fall & track;
            if (vs_rise)
                track <= i_en;
            else if (vs_fall)
                track <= 1'b0;
            // cleared at frame start
            // wraps mod 2^16
            if (vs_rise)
                acc <= (act & i_en) ? byte_sum : '0;
            else if (act & track)
                acc <= acc + byte_sum;
            // report only for a tracked frame
            if (vs_fall & track)
                o_rpt.sum <= acc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/usr_ctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module usr_ctrl_regs (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_usr_tx_wr,
    input  logic [usr_pkg::USR_DATA_W-1:0] i_usr_txd,
    input  logic                           i_usr_rx_rd,
    input  logic                           i_tim_done,
    input  vin_pkg::vin_timing_rpt_t       i_tim_rpt,
    input  vin_pkg::vin_sum_rpt_t          i_sum_rpt,
    output logic                           o_en,
    output logic [usr_pkg::USR_DATA_W-1:0] o_usr_rxd,
    output usr_pkg::usr_status_t           o_usr_status
);

    import vin_pkg::*;
    import usr_pkg::*;

    usr_op_e               op;
    usr_sel_e              sel_q;
    logic                  cmd_en;
    logic                  cmd_sel;
    logic                  cmd_clr;
    logic                  rd_sum;
    logic                  en_q;
    logic                  report_ready;
    logic                  overrun;
    logic [VIN_CNT_W-1:0]  frames;
    logic [VIN_CNT_W-1:0]  frames_base;
    vin_timing_rpt_t       tim_q;
    vin_sum_rpt_t          sum_q;
    logic [USR_DATA_W-1:0] rd_val;

    // --------------------
    // command decode
    // --------------------
    // opcode sits in the top nibble
    assign op      = usr_op_e'(i_usr_txd[15:12]);
    assign cmd_en  = i_usr_tx_wr & (op == OP_ENABLE);
    assign cmd_sel = i_usr_tx_wr & (op == OP_SELECT);
    assign cmd_clr = i_usr_tx_wr & (op == OP_CLEAR);
    // a read of the sum acknowledges the report
    assign rd_sum  = i_usr_rx_rd & (sel_q == SEL_SUM);
    // clear and done in one cycle still counts the new frame
    assign frames_base = cmd_clr ? '0 : frames;

    // read mux
    always_comb begin
        case (sel_q)
            SEL_LINES:  rd_val = tim_q.lines;
            SEL_WORDS:  rd_val = tim_q.words;
            SEL_SUM:    rd_val = sum_q.sum;
            SEL_FRAMES: rd_val = frames;
            default:    rd_val = '0;
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sel_q        <= SEL_LINES;
            en_q         <= 1'b0;
            report_ready <= 1'b0;
            overrun      <= 1'b0;
            frames       <= '0;
            tim_q        <= '0;
            sum_q        <= '0;
            o_usr_rxd    <= '0;
        end else begin
            if (cmd_en)
                en_q <= i_usr_txd[0];
            if (cmd_sel)
                sel_q <= usr_sel_e'(i_usr_txd[3:0]);
            if (cmd_clr)
                overrun <= 1'b0;
            // read data held until the next strobe
            if (i_usr_rx_rd)
                o_usr_rxd <= rd_val;
            if (rd_sum)
                report_ready <= 1'b0;
            frames <= frames_base;
            // end of frame, both reports arrive together
            if (i_tim_done) begin
                tim_q        <= i_tim_rpt;
                sum_q        <= i_sum_rpt;
                frames       <= frames_base + 1'b1;
                report_ready <= 1'b1;
                // previous report never collected
                if (report_ready & ~rd_sum)
                    overrun <= 1'b1;
            end
        end
    end

    // status byte, upper bits fixed at zero
    always_comb begin
        o_usr_status              = '0;
        o_usr_status.enable       = en_q;
        o_usr_status.report_ready = report_ready;
        o_usr_status.overrun      = overrun;
    end

    assign o_en = en_q;

endmodule

`default_nettype wire

// ==== hw/vin_capture_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vin_capture_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic [vin_pkg::VIN_WORD_W-1:0] i_vin_d,
    input  logic                           i_vin_vs,
    input  logic                           i_vin_hs,
    input  logic                           i_usr_tx_wr,
    input  logic [usr_pkg::USR_DATA_W-1:0] i_usr_txd,
    input  logic                           i_usr_rx_rd,
    output logic [usr_pkg::USR_DATA_W-1:0] o_usr_rxd,
    output usr_pkg::usr_status_t           o_usr_status
);

    import vin_pkg::*;

    logic            en;
    logic            tim_done;
    vin_timing_rpt_t tim_rpt;
    vin_sum_rpt_t    sum_rpt;

    // --------------------
    // stream side
    // --------------------
    vin_timing_monitor u_tim (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_en     (en),
        .i_vin_vs (i_vin_vs),
        .i_vin_hs (i_vin_hs),
        .o_done   (tim_done),
        .o_rpt    (tim_rpt)
    );

    // done coincides with the timing monitor, report is latched on that one
    vin_frame_checksum u_sum (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_en     (en),
        .i_vin_vs (i_vin_vs),
        .i_vin_hs (i_vin_hs),
        .i_vin_d  (i_vin_d),
        .o_done   (),
        .o_rpt    (sum_rpt)
    );

    // --------------------
    // user port
    // --------------------
    usr_ctrl_regs u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_usr_tx_wr  (i_usr_tx_wr),
        .i_usr_txd    (i_usr_txd),
        .i_usr_rx_rd  (i_usr_rx_rd),
        .i_tim_done   (tim_done),
        .i_tim_rpt    (tim_rpt),
        .i_sum_rpt    (sum_rpt),
        .o_en         (en),
        .o_usr_rxd    (o_usr_rxd),
        .o_usr_status (o_usr_status)
    );

endmodule

`default_nettype wire

// ==== test/vin_capture_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module vin_capture_sva (
    input logic                           i_clk,
    input logic                           i_rst_n,
    input logic                           i_usr_tx_wr,
    input logic [usr_pkg::USR_DATA_W-1:0] i_usr_txd,
    input logic                           o_en,
    input usr_pkg::usr_status_t           o_usr_status
);

    import usr_pkg::*;

    logic clr_cmd;

    // clear command on the user port
    assign clr_cmd = i_usr_tx_wr & (i_usr_txd[15:12] == OP_CLEAR);

    // --------------------
    // status byte
    // --------------------
    a_rsvd_zero: assert property (@(posedge i_clk) o_usr_status.rsvd == '0)
        else $error("reserved status bits are not zero");

    // overrun drops only after a clear, reset aside
    a_ovr_sticky: assert property (@(posedge i_clk)
        i_rst_n && $past(i_rst_n) && $fell(o_usr_status.overrun) |-> $past(clr_cmd))
        else $error("overrun fell without a clear command");

    // sync reset, enable low one edge later
    a_en_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_en)
        else $error("capture enable high during reset");

endmodule

bind usr_ctrl_regs vin_capture_sva u_sva (.*);

`default_nettype wire

// ==== test/tb_vin_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vin_capture;

    import vin_pkg::*;
    import usr_pkg::*;

    localparam int    PERIOD       = 100;
    localparam int    SKEW         = 10;
    localparam int    RST_CYCLES   = 8;
    localparam string PATTERN_FILE = "test/vin_capture_patterns.txt";

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [VIN_WORD_W-1:0] vin_d;
    logic                  vin_vs;
    logic                  vin_hs;
    logic                  tx_wr;
    logic [USR_DATA_W-1:0] txd;
    logic                  rx_rd;
    logic [USR_DATA_W-1:0] rxd;
    usr_status_t           status;

    // --------------------
    // reference model
    // --------------------
    logic        en_m;
    logic        rr_m;
    logic        ovr_m;
    logic [15:0] frames_m;
    logic [15:0] lines_m;
    logic [15:0] words_m;
    logic [15:0] sum_m;
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          limit;
    int          cycles = 0;

    vin_capture_top uut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_vin_d      (vin_d),
        .i_vin_vs     (vin_vs),
        .i_vin_hs     (vin_hs),
        .i_usr_tx_wr  (tx_wr),
        .i_usr_txd    (txd),
        .i_usr_rx_rd  (rx_rd),
        .o_usr_rxd    (rxd),
        .o_usr_status (status)
    );

    always #(PERIOD / 2) clk = ~clk;

    // run limit from the pattern budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the pattern run did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected register contents by select code
    function automatic logic [15:0] model_value(input logic [3:0] sel);
        case (sel)
            SEL_LINES:  return lines_m;
            SEL_WORDS:  return words_m;
            SEL_SUM:    return sum_m;
            SEL_FRAMES: return frames_m;
            default:    return '0;
        endcase
    endfunction

    // three xorshift draws cover the 80 bits
    task automatic random_word(output logic [VIN_WORD_W-1:0] w);
        logic [95:0] bits;
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            bits[i*32 +: 32] = rng;
        end
        w = bits[VIN_WORD_W-1:0];
    endtask

    // back to the drive point after the next edge
    task automatic next_cycle();
        @(posedge clk);
        #SKEW;
    endtask

    // caller sits at a falling edge
    task automatic check_status(input string name);
        logic [7:0] exp_status;
        exp_status = {5'b00000, ovr_m, rr_m, en_m};
        checks++;
        if (status !== exp_status) begin
            errors++;
            $display("** Error %0s status: expected %h, actual %h", name, exp_status, status);
        end
    endtask

    task automatic send_command(input logic [15:0] cmd);
        tx_wr = 1'b1;
        txd   = cmd;
        next_cycle();
        tx_wr = 1'b0;
        txd   = '0;
        case (cmd[15:12])
            OP_ENABLE: en_m = cmd[0];
            OP_CLEAR: begin
                frames_m = '0;
                ovr_m    = 1'b0;
            end
            default: ;
        endcase
    endtask

    // select first and then one read strobe
    // data valid after the next edge
    task automatic read_register(input logic [3:0] sel, input string name,
                                 input logic [15:0] exp_val);
        send_command({OP_SELECT, 8'h00, sel});
        rx_rd = 1'b1;
        next_cycle();
        rx_rd = 1'b0;
        // the sum read acknowledges the report
        if (sel == SEL_SUM)
            rr_m = 1'b0;
        @(negedge clk);
        checks++;
        if (rxd !== exp_val) begin
            errors++;
            $display("** Error %0s: expected %h, actual %h", name, exp_val, rxd);
        end
        check_status(name);
        next_cycle();
    endtask

    // all lines but the last carry w_first words
    task automatic drive_frame(input int n_lines, input int w_first, input int w_last,
                               input logic en_exp);
        logic [VIN_WORD_W-1:0] w;
        logic [15:0]           sum;
        logic                  tracked;
        int                    nw;
        checks++;
        if (status.enable !== en_exp) begin
            errors++;
            $display("** Error frame_enable: expected %0d, actual %0d", en_exp, status.enable);
        end
        tracked = en_m;
        sum     = '0;
        vin_vs  = 1'b1;
        next_cycle();
        for (int l = 0; l < n_lines; l++) begin
            nw     = (l == n_lines - 1) ? w_last : w_first;
            vin_hs = 1'b1;
            for (int k = 0; k < nw; k++) begin
                random_word(w);
                vin_d = w;
                for (int b = 0; b < VIN_LANES; b++)
                    sum = sum + {8'h00, w[b*VIN_LANE_W +: VIN_LANE_W]};
                next_cycle();
            end
            // one blank cycle between lines
            vin_hs = 1'b0;
            vin_d  = '0;
            next_cycle();
        end
        vin_vs = 1'b0;
        // vs fall to status is two cycles
        next_cycle();
        next_cycle();
        if (tracked) begin
            if (rr_m)
                ovr_m = 1'b1;
            rr_m     = 1'b1;
            frames_m = frames_m + 16'd1;
            lines_m  = 16'(n_lines);
            words_m  = 16'(w_last);
            sum_m    = sum;
        end
        @(negedge clk);
        check_status("frame");
        next_cycle();
    endtask

    // frame words plus 40 cycles per record
    task automatic plan_budget();
        int              fd;
        int              code;
        int              n_lines;
        int              w_first;
        int              w_last;
        int              en_i;
        logic [7:0]      ch;
        logic [8*80-1:0] text;
        limit = 0;
        fd    = $fopen(PATTERN_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, " %c", ch) == 1) begin
                if (ch == "F") begin
                    code  = $fscanf(fd, "%d %d %d %d", n_lines, w_first, w_last, en_i);
                    limit = limit + (n_lines - 1) * w_first + w_last;
                end
                if (ch != "#")
                    limit = limit + 40;
                code = $fgets(text, fd);
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // pattern run
    // --------------------
    initial begin : main
        int               fd;
        int               code;
        int               sel_i;
        int               n_lines;
        int               w_first;
        int               w_last;
        int               en_i;
        logic [7:0]       ch;
        logic [15:0]      cmd;
        logic [15:0]      exp_val;
        logic [8*24-1:0]  tname;
        logic [8*8-1:0]   tok;
        logic [8*80-1:0]  text;
        rst_n    = 1'b0;
        vin_d    = '0;
        vin_vs   = 1'b0;
        vin_hs   = 1'b0;
        tx_wr    = 1'b0;
        txd      = '0;
        rx_rd    = 1'b0;
        rng      = 32'd19641;
        en_m     = 1'b0;
        rr_m     = 1'b0;
        ovr_m    = 1'b0;
        frames_m = '0;
        lines_m  = '0;
        words_m  = '0;
        sum_m    = '0;
        errors   = 0;
        checks   = 0;
        plan_budget();
        repeat (RST_CYCLES) @(posedge clk);
        #SKEW;
        rst_n = 1'b1;
        next_cycle();
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file %0s", PATTERN_FILE);
        end else begin
            while ($fscanf(fd, " %c", ch) == 1) begin
                if (ch == "W") begin
                    code = $fscanf(fd, "%h", cmd);
                    send_command(cmd);
                    @(negedge clk);
                    check_status("command");
                    next_cycle();
                end else if (ch == "F") begin
                    code = $fscanf(fd, "%d %d %d %d", n_lines, w_first, w_last, en_i);
                    drive_frame(n_lines, w_first, w_last, en_i != 0);
                end else if (ch == "R") begin
                    tname = '0;
                    tok   = '0;
                    code  = $fscanf(fd, "%d %s %s", sel_i, tname, tok);
                    // a dash takes the model's value
                    if (tok == {56'd0, "-"})
                        exp_val = model_value(4'(sel_i));
                    else
                        code = $sscanf(string'(tok), "%h", exp_val);
                    read_register(4'(sel_i), string'(tname), exp_val);
                end else begin
                    code = $fgets(text, fd);
                end
            end
            $fclose(fd);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/vin_capture_patterns.txt ====
# W <command hex> | F <lines> <first-lines words> <last-line words> <enable 0/1>
# R <select 0..3> <test name> <expected hex, or - for the model value>
R 0 reset_lines 0
R 1 reset_words 0
R 2 reset_sum 0
R 3 reset_frames 0
W 1001
F 4 6 6 1
R 0 frame_lines 4
R 1 frame_words 6
R 3 frame_count 1
R 2 frame_sum -
W 1000
F 3 5 5 0
R 0 off_lines 4
R 1 off_words 6
R 3 off_frames 1
R 2 off_sum -
W 1001
F 2 4 4 1
F 5 3 3 1
R 0 ovr_lines 5
R 1 ovr_words 3
R 3 ovr_frames 3
R 2 ovr_sum -
W 3000
R 3 clr_frames 0
F 6 8 2 1
R 0 ragged_lines 6
R 1 ragged_words 2
R 3 ragged_frames 1
R 2 ragged_sum -

// ==== files.f ====
hw/vin_pkg.sv
hw/usr_pkg.sv
hw/vin_timing_monitor.sv
hw/vin_frame_checksum.sv
hw/usr_ctrl_regs.sv
hw/vin_capture_top.sv
test/vin_capture_sva.sv
test/tb_vin_capture.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_vin_capture
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the grep on the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
